/* logic/post_config.svh */
`ifndef POST_CONFIG_SVH
`define POST_CONFIG_SVH

// APB register interface
`define REG_ADDRWIDTH 8
`define REG_DATAWIDTH 32

// datapath widths
`define DWIDTH        16
`define MAX_BITS_POOL 3
`define JOB_LEN_WIDTH 16
// inv_var is unsigned Q.4
`define NORM_FRAC     4
`define INV_VAR_ONE   16

// activation encodings, leaky divides negatives by 8
`define ACT_LEAKY     1'b0
`define ACT_RELU      1'b1
`define LEAKY_SHIFT   3

// buffering and credit counts
`define IN_FIFO_DEPTH  4
`define MID_FIFO_DEPTH 4
`define OUT_CREDITS    2

// register map
`define REG_ENABLES_ADDR        8'h00
`define REG_STDN_ADDR           8'h04
`define REG_MEAN_ADDR           8'h08
`define REG_INV_VAR_ADDR        8'h0C
`define REG_POOL_KERNEL_SIZE    8'h10
`define REG_ACTIVATION_CSR_ADDR 8'h14
`define REG_JOB_LEN_ADDR        8'h18

`endif

/* logic/post_pkg.sv */
`include "post_config.svh"

package post_pkg;

    // configuration as programmed through the register file
    typedef struct packed {
        logic                       enable_norm;
        logic                       enable_pool;
        logic                       enable_activation;
        // 1 selects ReLU, 0 selects leaky
        logic                       activation_type;
        // two's complement
        logic [`DWIDTH-1:0]         mean;
        // unsigned, NORM_FRAC fraction bits
        logic [`DWIDTH-1:0]         inv_var;
        // 0 behaves like 1
        logic [`MAX_BITS_POOL-1:0]  kernel_size;
        // number of input words per job
        logic [`JOB_LEN_WIDTH-1:0]  job_len;
    } post_cfg_t;

    // one element of the stream between execute and result
    typedef struct packed {
        // two's complement word
        logic [`DWIDTH-1:0] data;
        // final element of the current job
        logic               last;
    } post_beat_t;

endpackage

/* logic/post_regs.sv */
`timescale 1ns/1ps
`include "post_config.svh"

module post_regs (
    input  logic                      PCLK,
    input  logic                      PRESETn,
    input  logic [`REG_ADDRWIDTH-1:0] PADDR,
    input  logic                      PWRITE,
    input  logic                      PSEL,
    input  logic                      PENABLE,
    input  logic [`REG_DATAWIDTH-1:0] PWDATA,
    output logic [`REG_DATAWIDTH-1:0] PRDATA,
    output logic                      PREADY,
    input  logic                      job_done,
    output post_pkg::post_cfg_t       cfg,
    output logic                      start
);

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_read
    } apb_state_t;

    apb_state_t                state;
    // sticky completion flag, reads back in bit 31 of STDN
    logic                      done;
    // catches every access to an unmapped address
    logic [`REG_DATAWIDTH-1:0] reg_dummy;

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            state                 <= st_idle;
            PRDATA                <= '0;
            PREADY                <= 1'b0;
            start                 <= 1'b0;
            done                  <= 1'b0;
            reg_dummy             <= '0;
            cfg.enable_norm       <= 1'b0;
            cfg.enable_pool       <= 1'b0;
            cfg.enable_activation <= 1'b0;
            cfg.activation_type   <= `ACT_RELU;
            cfg.mean              <= '0;
            cfg.inv_var           <= `DWIDTH'(`INV_VAR_ONE);
            cfg.kernel_size       <= `MAX_BITS_POOL'(1);
            cfg.job_len           <= '0;
        end else begin
            // start is a single-cycle strobe
            start <= 1'b0;
            if (job_done) begin
                done <= 1'b1;
            end

            case (state)
                st_idle: begin
                    PREADY <= 1'b0;
                    PRDATA <= '0;
                    // only a setup phase opens a transfer
                    if (PSEL && !PENABLE) begin
                        state <= PWRITE ? st_write : st_read;
                    end
                end

                st_write: begin
                    if (PSEL && PWRITE && PENABLE) begin
                        PREADY <= 1'b1;
                        case (PADDR)
                            `REG_ENABLES_ADDR: begin
                                cfg.enable_activation <= PWDATA[2];
                                cfg.enable_pool       <= PWDATA[1];
                                cfg.enable_norm       <= PWDATA[0];
                            end
                            `REG_STDN_ADDR: begin
                                // a new job clears the previous done
                                if (PWDATA[0]) begin
                                    start <= 1'b1;
                                    done  <= 1'b0;
                                end
                            end
                            `REG_MEAN_ADDR:           cfg.mean <= PWDATA[`DWIDTH-1:0];
                            `REG_INV_VAR_ADDR:        cfg.inv_var <= PWDATA[`DWIDTH-1:0];
                            `REG_POOL_KERNEL_SIZE:    cfg.kernel_size <= PWDATA[`MAX_BITS_POOL-1:0];
                            `REG_ACTIVATION_CSR_ADDR: cfg.activation_type <= PWDATA[0];
                            `REG_JOB_LEN_ADDR:        cfg.job_len <= PWDATA[`JOB_LEN_WIDTH-1:0];
                            default:                  reg_dummy <= PWDATA;
                        endcase
                    end
                    state <= st_idle;
                end

                st_read: begin
                    if (PSEL && !PWRITE && PENABLE) begin
                        PREADY <= 1'b1;
                        case (PADDR)
                            `REG_ENABLES_ADDR:
                                PRDATA <= {{(`REG_DATAWIDTH-3){1'b0}}, cfg.enable_activation,
                                           cfg.enable_pool, cfg.enable_norm};
                            `REG_STDN_ADDR:
                                PRDATA <= {done, {(`REG_DATAWIDTH-1){1'b0}}};
                            `REG_MEAN_ADDR:
                                PRDATA <= {{(`REG_DATAWIDTH-`DWIDTH){1'b0}}, cfg.mean};
                            `REG_INV_VAR_ADDR:
                                PRDATA <= {{(`REG_DATAWIDTH-`DWIDTH){1'b0}}, cfg.inv_var};
                            `REG_POOL_KERNEL_SIZE:
                                PRDATA <= {{(`REG_DATAWIDTH-`MAX_BITS_POOL){1'b0}},
                                           cfg.kernel_size};
                            `REG_ACTIVATION_CSR_ADDR:
                                PRDATA <= {{(`REG_DATAWIDTH-1){1'b0}}, cfg.activation_type};
                            `REG_JOB_LEN_ADDR:
                                PRDATA <= {{(`REG_DATAWIDTH-`JOB_LEN_WIDTH){1'b0}}, cfg.job_len};
                            default:
                                PRDATA <= reg_dummy;
                        endcase
                    end
                    state <= st_idle;
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // access phase must stay inside a selected transfer
    a_penable_needs_psel: assert property (
        @(posedge PCLK) disable iff (!PRESETn) PENABLE |-> PSEL
    ) else $error("PENABLE high without PSEL");

endmodule

/* logic/credit_fifo.sv */
`timescale 1ns/1ps
`include "post_config.svh"

module credit_fifo #(
    parameter type payload_t = logic [`DWIDTH-1:0],
    parameter int  depth     = `IN_FIFO_DEPTH
) (
    input  logic     PCLK,
    input  logic     PRESETn,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     not_empty,
    output logic     credit
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_pop;

    assign not_empty = (count != '0);
    assign do_pop    = pop && not_empty;
    // one credit back upstream per item that leaves
    assign credit    = do_pop;
    assign pop_data  = mem[rd_ptr];

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge PCLK) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // a push into a full buffer means the producer overspent its credits
    a_no_push_when_full: assert property (
        @(posedge PCLK) disable iff (!PRESETn) push |-> (count < depth)
    ) else $error("credit_fifo push while full");

endmodule

/* logic/post_execute.sv */
`timescale 1ns/1ps
`include "post_config.svh"

module post_execute (
    input  logic                 PCLK,
    input  logic                 PRESETn,
    input  post_pkg::post_cfg_t  cfg,
    input  logic                 start,
    input  logic                 in_avail,
    input  logic [`DWIDTH-1:0]   in_word,
    output logic                 in_pop,
    input  logic                 mid_credit,
    output logic                 mid_push,
    output post_pkg::post_beat_t mid_beat
);
    import post_pkg::*;

    localparam int cred_w = $clog2(`MID_FIFO_DEPTH + 1);

    logic                        active;
    logic [`JOB_LEN_WIDTH-1:0]   taken;
    logic [cred_w-1:0]           credits;
    logic                        take_last;
    logic signed [`DWIDTH:0]     diff;
    logic signed [2*`DWIDTH+1:0] prod;
    logic [`DWIDTH-1:0]          norm_word;
    logic [`DWIDTH-1:0]          act_word;
    post_beat_t                  s1_beat;
    logic                        s1_valid;

    // a credit is spent at pop time, covering the word until it lands in the mid FIFO
    assign in_pop    = active && in_avail && (credits != '0) && (taken < cfg.job_len);
    assign take_last = (taken + 1'b1 == cfg.job_len);

    // stage 1: (x - mean) * inv_var, then drop the fraction bits
    always_comb begin
        diff      = $signed({in_word[`DWIDTH-1], in_word})
                  - $signed({cfg.mean[`DWIDTH-1], cfg.mean});
        prod      = diff * $signed({1'b0, cfg.inv_var});
        norm_word = cfg.enable_norm ? prod[`DWIDTH+`NORM_FRAC-1:`NORM_FRAC] : in_word;
    end

    // stage 2: activation only touches negative values
    always_comb begin
        act_word = s1_beat.data;
        if (cfg.enable_activation && s1_beat.data[`DWIDTH-1]) begin
            if (cfg.activation_type == `ACT_RELU) begin
                act_word = '0;
            end else begin
                act_word = $signed(s1_beat.data) >>> `LEAKY_SHIFT;
            end
        end
    end

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            active   <= 1'b0;
            taken    <= '0;
            credits  <= cred_w'(`MID_FIFO_DEPTH);
            s1_valid <= 1'b0;
            mid_push <= 1'b0;
        end else begin
            if (start) begin
                // an empty job never becomes active
                active <= (cfg.job_len != '0);
                taken  <= '0;
            end else if (in_pop) begin
                taken <= taken + 1'b1;
                if (take_last) begin
                    active <= 1'b0;
                end
            end
            credits  <= credits - cred_w'(in_pop) + cred_w'(mid_credit);
            s1_valid <= in_pop;
            mid_push <= s1_valid;
        end
    end

    always_ff @(posedge PCLK) begin
        if (in_pop) begin
            s1_beat.data <= norm_word;
            s1_beat.last <= take_last;
        end
        if (s1_valid) begin
            mid_beat.data <= act_word;
            mid_beat.last <= s1_beat.last;
        end
    end

endmodule

/* logic/post_result.sv */
`timescale 1ns/1ps
`include "post_config.svh"

module post_result (
    input  logic                 PCLK,
    input  logic                 PRESETn,
    input  post_pkg::post_cfg_t  cfg,
    input  logic                 beat_avail,
    input  post_pkg::post_beat_t beat,
    output logic                 beat_pop,
    output logic                 out_valid,
    output logic [`DWIDTH-1:0]   out_data,
    input  logic                 out_credit,
    output logic                 job_done
);

    localparam int cred_w = $clog2(`OUT_CREDITS + 1);

    logic [cred_w-1:0]         credits;
    logic [`MAX_BITS_POOL-1:0] fill;
    logic [`MAX_BITS_POOL-1:0] k_eff;
    logic [`DWIDTH-1:0]        acc;
    logic [`DWIDTH-1:0]        window_max;
    logic                      win_full;
    logic                      emit;
    logic                      out_last;

    assign k_eff = (cfg.kernel_size == '0) ? `MAX_BITS_POOL'(1) : cfg.kernel_size;

    // no pops without a credit, so the window stays put while the sink stalls
    assign beat_pop = beat_avail && (credits != '0);

    // fill counts beats already folded into acc
    assign win_full   = (fill == k_eff - 1'b1);
    assign window_max = ((fill == '0) || ($signed(beat.data) > $signed(acc))) ? beat.data : acc;

    // last flushes a partial window
    assign emit = beat_pop && (!cfg.enable_pool || win_full || beat.last);

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            credits   <= cred_w'(`OUT_CREDITS);
            fill      <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            job_done  <= 1'b0;
        end else begin
            credits   <= credits - cred_w'(emit) + cred_w'(out_credit);
            out_valid <= emit;
            out_last  <= emit && beat.last;
            // one cycle after the final beat has left
            job_done  <= out_valid && out_last;
            if (emit) begin
                fill <= '0;
            end else if (beat_pop) begin
                fill <= fill + 1'b1;
            end
        end
    end

    always_ff @(posedge PCLK) begin
        if (beat_pop) begin
            acc <= window_max;
        end
        if (emit) begin
            out_data <= window_max;
        end
    end

    // sink may never return more credits than it was given
    a_credit_bound: assert property (
        @(posedge PCLK) disable iff (!PRESETn) credits <= `OUT_CREDITS
    ) else $error("output credit counter above OUT_CREDITS");

endmodule

/* logic/post_unit_top.sv */
`timescale 1ns/1ps
`include "post_config.svh"

module post_unit_top (
    input  logic                      PCLK,
    input  logic                      PRESETn,
    input  logic [`REG_ADDRWIDTH-1:0] PADDR,
    input  logic                      PWRITE,
    input  logic                      PSEL,
    input  logic                      PENABLE,
    input  logic [`REG_DATAWIDTH-1:0] PWDATA,
    output logic [`REG_DATAWIDTH-1:0] PRDATA,
    output logic                      PREADY,
    input  logic                      in_valid,
    input  logic [`DWIDTH-1:0]        in_data,
    output logic                      in_credit,
    output logic                      out_valid,
    output logic [`DWIDTH-1:0]        out_data,
    input  logic                      out_credit
);
    import post_pkg::*;

    post_cfg_t          cfg;
    logic               start;
    logic               job_done;
    // input FIFO to execute
    logic               in_avail;
    logic [`DWIDTH-1:0] in_word;
    logic               in_pop;
    // execute to result through the mid FIFO
    logic               mid_push;
    post_beat_t         mid_beat;
    logic               mid_credit;
    logic               beat_avail;
    post_beat_t         beat;
    logic               beat_pop;

    post_regs i_post_regs (
        .PCLK     (PCLK),
        .PRESETn  (PRESETn),
        .PADDR    (PADDR),
        .PWRITE   (PWRITE),
        .PSEL     (PSEL),
        .PENABLE  (PENABLE),
        .PWDATA   (PWDATA),
        .PRDATA   (PRDATA),
        .PREADY   (PREADY),
        .job_done (job_done),
        .cfg      (cfg),
        .start    (start)
    );

    credit_fifo #(
        .payload_t (logic [`DWIDTH-1:0]),
        .depth     (`IN_FIFO_DEPTH)
    ) i_in_fifo (
        .PCLK      (PCLK),
        .PRESETn   (PRESETn),
        .push      (in_valid),
        .push_data (in_data),
        .pop       (in_pop),
        .pop_data  (in_word),
        .not_empty (in_avail),
        .credit    (in_credit)
    );

    post_execute i_post_execute (
        .PCLK       (PCLK),
        .PRESETn    (PRESETn),
        .cfg        (cfg),
        .start      (start),
        .in_avail   (in_avail),
        .in_word    (in_word),
        .in_pop     (in_pop),
        .mid_credit (mid_credit),
        .mid_push   (mid_push),
        .mid_beat   (mid_beat)
    );

    credit_fifo #(
        .payload_t (post_beat_t),
        .depth     (`MID_FIFO_DEPTH)
    ) i_mid_fifo (
        .PCLK      (PCLK),
        .PRESETn   (PRESETn),
        .push      (mid_push),
        .push_data (mid_beat),
        .pop       (beat_pop),
        .pop_data  (beat),
        .not_empty (beat_avail),
        .credit    (mid_credit)
    );

    post_result i_post_result (
        .PCLK       (PCLK),
        .PRESETn    (PRESETn),
        .cfg        (cfg),
        .beat_avail (beat_avail),
        .beat       (beat),
        .beat_pop   (beat_pop),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit),
        .job_done   (job_done)
    );

endmodule

/* verif/post_unit_tb.sv */
`timescale 1ns/1ps
`include "post_config.svh"

module post_unit_tb;

    localparam int clk_period = 4;
    localparam logic [31:0] lfsr_seed = 32'h957d_0269;
    // job lengths also size the watchdog
    localparam int len_pass  = 20;
    localparam int len_norm  = 16;
    localparam int len_pool  = 11;
    localparam int len_stall = 25;
    localparam int total_words = len_pass + 2 * len_norm + 4 * len_pool + len_stall;
    localparam int budget_cycles = 3000 + total_words * 300;

    logic                      PCLK;
    logic                      PRESETn;
    logic [`REG_ADDRWIDTH-1:0] PADDR;
    logic                      PWRITE;
    logic                      PSEL;
    logic                      PENABLE;
    logic [`REG_DATAWIDTH-1:0] PWDATA;
    logic [`REG_DATAWIDTH-1:0] PRDATA;
    logic                      PREADY;
    logic                      in_valid;
    logic [`DWIDTH-1:0]        in_data;
    logic                      in_credit;
    logic                      out_valid;
    logic [`DWIDTH-1:0]        out_data;
    logic                      out_credit;

    int checks = 0;
    int errors = 0;
    int out_count = 0;
    logic long_stall = 1'b0;
    logic [31:0] stim_state = lfsr_seed;
    logic [31:0] sink_state = lfsr_seed;

    logic [`DWIDTH-1:0] src_q[$];
    logic [`DWIDTH-1:0] exp_q[$];
    logic [`DWIDTH-1:0] job_words[$];

    // shadow of the programmed configuration
    logic                      t_norm;
    logic                      t_pool;
    logic                      t_act;
    logic                      t_relu;
    logic [`DWIDTH-1:0]        t_mean;
    logic [`DWIDTH-1:0]        t_inv;
    logic [`MAX_BITS_POOL-1:0] t_k;

    post_unit_top i_post_unit_top (
        .PCLK       (PCLK),
        .PRESETn    (PRESETn),
        .PADDR      (PADDR),
        .PWRITE     (PWRITE),
        .PSEL       (PSEL),
        .PENABLE    (PENABLE),
        .PWDATA     (PWDATA),
        .PRDATA     (PRDATA),
        .PREADY     (PREADY),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

    initial begin
        PCLK = 1'b0;
        forever #(clk_period / 2) PCLK = ~PCLK;
    end

    // galois form of x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], state[0]};
            state = lfsr_step(state);
        end
        return val;
    endfunction

    // normalization then activation for one word
    function automatic logic [`DWIDTH-1:0] norm_act(input logic [`DWIDTH-1:0] x);
        longint v;
        logic [`DWIDTH-1:0] y;
        y = x;
        if (t_norm) begin
            v = (longint'($signed(x)) - longint'($signed(t_mean))) * longint'(t_inv);
            v = v >>> `NORM_FRAC;
            y = v[`DWIDTH-1:0];
        end
        if (t_act && y[`DWIDTH-1]) begin
            // relu clamps and leaky divides by 8
            if (t_relu) begin
                y = '0;
            end else begin
                y = $signed(y) >>> 3;
            end
        end
        return y;
    endfunction

    function automatic void build_expected();
        logic [`DWIDTH-1:0] cur;
        logic [`DWIDTH-1:0] best;
        int fill;
        int k;
        k = (t_k == 0) ? 1 : int'(t_k);
        fill = 0;
        best = '0;
        foreach (job_words[i]) begin
            cur = norm_act(job_words[i]);
            if (!t_pool) begin
                exp_q.push_back(cur);
            end else begin
                if (fill == 0 || $signed(cur) > $signed(best)) begin
                    best = cur;
                end
                fill++;
                // a short final window is flushed too
                if (fill == k || i == job_words.size() - 1) begin
                    exp_q.push_back(best);
                    fill = 0;
                end
            end
        end
    endfunction

    task automatic apb_transfer(input logic write, input logic [`REG_ADDRWIDTH-1:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int wait_cycles;
        @(posedge PCLK);
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= write;
        PADDR   <= addr;
        PWDATA  <= wdata;
        @(posedge PCLK);
        PENABLE <= 1'b1;
        wait_cycles = 0;
        @(posedge PCLK);
        while (!PREADY && wait_cycles < 8) begin
            @(posedge PCLK);
            wait_cycles++;
        end
        if (!PREADY) begin
            errors++;
            $display("APB transfer to address %h never got PREADY", addr);
        end else if (wait_cycles != 1) begin
            errors++;
            $display("APB transfer to address %h did not take three cycles", addr);
        end
        rdata = PRDATA;
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    task automatic apb_write(input logic [`REG_ADDRWIDTH-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [`REG_ADDRWIDTH-1:0] addr, output logic [31:0] data);
        apb_transfer(1'b0, addr, '0, data);
    endtask

    task automatic check_reg(input logic [`REG_ADDRWIDTH-1:0] addr, input logic [31:0] expected);
        logic [31:0] rd;
        apb_read(addr, rd);
        checks++;
        if (rd !== expected) begin
            errors++;
            $display("Fail %0t PRDATA at %h expected %h got %h", $time, addr, expected, rd);
        end
    endtask

    task automatic run_job(input logic [2:0] enables, input logic relu,
                           input logic [15:0] mean, input logic [15:0] inv,
                           input logic [2:0] k, input int len, input logic stall);
        logic [31:0] rd;
        int polls;
        int exp_count;
        apb_write(`REG_ENABLES_ADDR, {29'b0, enables});
        apb_write(`REG_MEAN_ADDR, {16'b0, mean});
        apb_write(`REG_INV_VAR_ADDR, {16'b0, inv});
        apb_write(`REG_POOL_KERNEL_SIZE, {29'b0, k});
        apb_write(`REG_ACTIVATION_CSR_ADDR, {31'b0, relu});
        apb_write(`REG_JOB_LEN_ADDR, len);
        {t_act, t_pool, t_norm} = enables;
        t_relu = relu;
        t_mean = mean;
        t_inv  = inv;
        t_k    = k;
        long_stall = stall;
        job_words.delete();
        for (int i = 0; i < len; i++) begin
            job_words.push_back(`DWIDTH'(take_bits(stim_state, `DWIDTH)));
            src_q.push_back(job_words[i]);
        end
        build_expected();
        exp_count = t_pool ? (len + ((k == 0) ? 1 : k) - 1) / ((k == 0) ? 1 : k) : len;
        out_count = 0;
        apb_write(`REG_STDN_ADDR, 32'h1);
        apb_read(`REG_STDN_ADDR, rd);
        checks++;
        if (rd[31]) begin
            errors++;
            $display("Fail %0t done expected 0 got %0b", $time, rd[31]);
        end
        polls = 0;
        while (!rd[31] && polls < 100 + len * 80) begin
            apb_read(`REG_STDN_ADDR, rd);
            polls++;
        end
        checks++;
        if (!rd[31]) begin
            errors++;
            $display("done bit never set for job of %0d words", len);
        end
        checks++;
        if (out_count != exp_count) begin
            errors++;
            $display("Fail %0t out_count expected %0d got %0d", $time, exp_count, out_count);
        end else if (exp_q.size() != 0) begin
            errors++;
            $display("job of %0d words left %0d expected results unmatched", len, exp_q.size());
        end
        exp_q.delete();
    endtask

    // source spends a credit per word and regains one per in_credit pulse
    initial begin : source
        int credits;
        in_valid = 1'b0;
        in_data  = '0;
        credits  = `IN_FIFO_DEPTH;
        forever begin
            @(posedge PCLK);
            if (PRESETn) begin
                if (in_credit) begin
                    credits++;
                end
                if (credits > `IN_FIFO_DEPTH) begin
                    errors++;
                    $display("more input credits returned than words sent (%0d) at %0t",
                             credits, $time);
                end
                if (src_q.size() > 0 && credits > 0) begin
                    in_valid <= 1'b1;
                    in_data  <= src_q.pop_front();
                    credits--;
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    end

    // sink returns each credit after a random delay
    initial begin : sink
        int pending;
        int delay;
        int sink_credits;
        out_credit   = 1'b0;
        pending      = 0;
        delay        = 0;
        sink_credits = `OUT_CREDITS;
        forever begin
            @(posedge PCLK);
            if (PRESETn) begin
                if (out_valid) begin
                    if (sink_credits == 0) begin
                        errors++;
                        $display("output beat at %0t arrived while the sink held no credit", $time);
                    end else begin
                        sink_credits--;
                    end
                    pending++;
                end
                if (pending > 0 && delay == 0) begin
                    out_credit <= 1'b1;
                    pending--;
                    sink_credits++;
                    delay = long_stall ? take_bits(sink_state, 6) : take_bits(sink_state, 2);
                end else begin
                    out_credit <= 1'b0;
                    if (delay > 0) begin
                        delay--;
                    end
                end
            end
        end
    end

    initial begin : compare
        logic [`DWIDTH-1:0] exp_word;
        forever begin
            @(posedge PCLK);
            if (PRESETn && out_valid) begin
                out_count++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected output %h at %0t with no result pending", out_data, $time);
                end else begin
                    exp_word = exp_q.pop_front();
                    checks++;
                    if (out_data !== exp_word) begin
                        errors++;
                        $display("Fail %0t out_data expected %h got %h", $time, exp_word, out_data);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(budget_cycles * clk_period);
        $display("timeout after %0d cycles, the run did not finish", budget_cycles);
        $display("checks: %0d errors: %0d", checks, errors);
        $display("Test FAILED");
        $finish;
    end

    initial begin : run_tests
        PRESETn = 1'b0;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        repeat (5) @(posedge PCLK);
        PRESETn <= 1'b1;
        @(posedge PCLK);

        // reset values
        check_reg(`REG_ENABLES_ADDR, 32'h0);
        check_reg(`REG_STDN_ADDR, 32'h0);
        check_reg(`REG_MEAN_ADDR, 32'h0);
        check_reg(`REG_INV_VAR_ADDR, 32'd16);
        check_reg(`REG_POOL_KERNEL_SIZE, 32'h1);
        check_reg(`REG_ACTIVATION_CSR_ADDR, 32'h1);
        check_reg(`REG_JOB_LEN_ADDR, 32'h0);
        check_reg(8'h20, 32'h0);

        // field placement and masking on readback
        apb_write(`REG_ENABLES_ADDR, 32'hFFFF_FFFD);
        check_reg(`REG_ENABLES_ADDR, 32'h5);
        apb_write(`REG_MEAN_ADDR, 32'h1234_ABCD);
        check_reg(`REG_MEAN_ADDR, 32'h0000_ABCD);
        apb_write(`REG_INV_VAR_ADDR, 32'hDEAD_0033);
        check_reg(`REG_INV_VAR_ADDR, 32'h0000_0033);
        apb_write(`REG_POOL_KERNEL_SIZE, 32'hF);
        check_reg(`REG_POOL_KERNEL_SIZE, 32'h7);
        apb_write(`REG_ACTIVATION_CSR_ADDR, 32'h2);
        check_reg(`REG_ACTIVATION_CSR_ADDR, 32'h0);
        apb_write(`REG_JOB_LEN_ADDR, 32'hABCD_0102);
        check_reg(`REG_JOB_LEN_ADDR, 32'h0000_0102);
        apb_write(`REG_STDN_ADDR, 32'h8000_0000);
        check_reg(`REG_STDN_ADDR, 32'h0);
        // all unmapped addresses share one register
        apb_write(8'h20, 32'hCAFE_0001);
        apb_write(8'hFC, 32'h5A5A_A5A5);
        check_reg(8'h20, 32'h5A5A_A5A5);
        check_reg(8'h1C, 32'h5A5A_A5A5);

        run_job(3'b000, 1'b1, 16'd0, 16'd16, 3'd1, len_pass, 1'b0);
        run_job(3'b101, 1'b1, 16'd100, 16'd24, 3'd1, len_norm, 1'b0);
        run_job(3'b101, 1'b0, 16'hFFCE, 16'd40, 3'd1, len_norm, 1'b0);
        for (int k = 1; k <= 4; k++) begin
            run_job(3'b010, 1'b1, 16'd0, 16'd16, 3'(k), len_pool, 1'b0);
        end
        // long credit stalls back the stream up into the source
        run_job(3'b101, 1'b1, 16'hFF00, 16'd8, 3'd1, len_stall, 1'b1);

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/post_pkg.sv
logic/post_regs.sv
logic/credit_fifo.sv
logic/post_execute.sv
logic/post_result.sv
logic/post_unit_top.sv
verif/post_unit_tb.sv

/* Bender.yml */
package:
  name: post_unit

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/post_pkg.sv
      - logic/post_regs.sv
      - logic/credit_fifo.sv
      - logic/post_execute.sv
      - logic/post_result.sv
      - logic/post_unit_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/post_unit_tb.sv
